// File: hw/core_pkg.sv
package core_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam int queue_depth = 4;
    localparam int queue_ptr_w = $clog2(queue_depth);
    localparam logic [xlen-1:0] reset_pc = '0;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // funct field of special, instr[5:0]
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_lui
    } alu_op_e;

    typedef struct packed {
        logic [xlen-1:0] instr;
        logic [xlen-1:0] pc;
    } queue_entry_t;

    // execute to load/store unit, held until done
    typedef struct packed {
        logic            valid;
        logic            we;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } ls_req_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic                  rf_wen;
        logic [reg_addr_w-1:0] rf_wnum;
        logic [xlen-1:0]       rf_wdata;
    } commit_t;

endpackage

// File: hw/bus_pkg.sv
package bus_pkg;

    localparam int wb_adr_w = 32;
    localparam int wb_dat_w = 32;

    // master to slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [wb_adr_w-1:0]   adr;
        logic [wb_dat_w-1:0]   dat;
        logic [wb_dat_w/8-1:0] sel;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                ack;
        logic [wb_dat_w-1:0] dat;
    } wb_rsp_t;

endpackage

// File: hw/fetch_queue.sv
module fetch_queue (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    output bus_pkg::wb_req_t              fetch_req_o,
    input  bus_pkg::wb_rsp_t              fetch_rsp_i,
    output core_pkg::queue_entry_t        head_o,
    output logic                          head_valid_o,
    input  logic                          pop_i,
    input  logic                          redirect_valid_i,
    input  logic [core_pkg::xlen-1:0]     redirect_pc_i
);

    core_pkg::queue_entry_t               mem_q [core_pkg::queue_depth];
    logic [core_pkg::queue_ptr_w-1:0]     wr_ptr_q;
    logic [core_pkg::queue_ptr_w-1:0]     rd_ptr_q;
    logic [core_pkg::queue_ptr_w:0]       count_q;
    logic [core_pkg::xlen-1:0]            pc_q;
    logic [bus_pkg::wb_adr_w-1:0]         fetch_adr_q;
    logic                                 cyc_q;
    logic                                 discard_q;
    logic                                 ack;
    logic                                 push;
    logic                                 pop;
    logic                                 start;

    assign ack   = cyc_q && fetch_rsp_i.ack;
    assign push  = ack && !discard_q && !redirect_valid_i;
    assign pop   = pop_i && head_valid_o;
    // a full queue holds fetch back
    assign start = !cyc_q && !redirect_valid_i && (int'(count_q) < core_pkg::queue_depth);

    assign head_o       = mem_q[rd_ptr_q];
    assign head_valid_o = (count_q != '0);

    always_comb begin
        fetch_req_o     = '0;
        fetch_req_o.cyc = cyc_q;
        fetch_req_o.stb = cyc_q;
        fetch_req_o.adr = fetch_adr_q;
        fetch_req_o.sel = '1;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q      <= core_pkg::reset_pc;
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            cyc_q     <= 1'b0;
            discard_q <= 1'b0;
        end else begin
            if (start) begin
                cyc_q <= 1'b1;
            end else if (ack) begin
                cyc_q <= 1'b0;
            end

            if (redirect_valid_i) begin
                pc_q      <= redirect_pc_i;
                wr_ptr_q  <= '0;
                rd_ptr_q  <= '0;
                count_q   <= '0;
                // fetch still on the bus belongs to the old path
                discard_q <= cyc_q && !fetch_rsp_i.ack;
            end else begin
                if (ack) begin
                    discard_q <= 1'b0;
                end
                if (push) begin
                    pc_q     <= pc_q + 'd4;
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
                if (pop) begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
                case ({push, pop})
                    2'b10:   count_q <= count_q + 1'b1;
                    2'b01:   count_q <= count_q - 1'b1;
                    default: count_q <= count_q;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            fetch_adr_q <= pc_q;
        end
        if (push) begin
            mem_q[wr_ptr_q] <= '{instr: fetch_rsp_i.dat, pc: fetch_adr_q};
        end
    end

endmodule

// File: hw/regfile.sv
module regfile (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic [core_pkg::reg_addr_w-1:0] ra_i,
    input  logic [core_pkg::reg_addr_w-1:0] rb_i,
    output logic [core_pkg::xlen-1:0]       rda_o,
    output logic [core_pkg::xlen-1:0]       rdb_o,
    input  logic                            we_i,
    input  logic [core_pkg::reg_addr_w-1:0] wa_i,
    input  logic [core_pkg::xlen-1:0]       wd_i
);

    logic [core_pkg::xlen-1:0] regs_q [2**core_pkg::reg_addr_w];

    // r0 reads as zero
    assign rda_o = (ra_i == '0) ? '0 : regs_q[ra_i];
    assign rdb_o = (rb_i == '0) ? '0 : regs_q[rb_i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 2**core_pkg::reg_addr_w; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && wa_i != '0) begin
            regs_q[wa_i] <= wd_i;
        end
    end

endmodule

// File: hw/decode_exec.sv
module decode_exec (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  core_pkg::queue_entry_t          head_i,
    input  logic                            head_valid_i,
    output logic                            pop_o,
    output logic                            redirect_valid_o,
    output logic [core_pkg::xlen-1:0]       redirect_pc_o,
    output logic [core_pkg::reg_addr_w-1:0] rs_addr_o,
    output logic [core_pkg::reg_addr_w-1:0] rt_addr_o,
    input  logic [core_pkg::xlen-1:0]       rs_data_i,
    input  logic [core_pkg::xlen-1:0]       rt_data_i,
    output logic                            wen_o,
    output logic [core_pkg::reg_addr_w-1:0] waddr_o,
    output logic [core_pkg::xlen-1:0]       wdata_o,
    output core_pkg::ls_req_t               ls_req_o,
    input  logic                            ls_done_i,
    input  logic [core_pkg::xlen-1:0]       ls_rdata_i,
    output core_pkg::commit_t               commit_o
);

    core_pkg::opcode_e               op;
    core_pkg::funct_e                funct;
    core_pkg::alu_op_e               alu_op;
    logic [core_pkg::reg_addr_w-1:0] rd;
    logic [core_pkg::reg_addr_w-1:0] dest;
    logic [4:0]                      shamt;
    logic [15:0]                     imm;
    logic [25:0]                     jtarget;
    logic                            sel_a_shamt;
    logic                            sel_b_imm;
    logic                            zero_ext;
    logic                            has_dest;
    logic                            ls_op;
    logic                            taken;
    logic                            issue;
    logic                            ls_finish;
    logic                            wr_dest;
    logic [core_pkg::xlen-1:0]       imm_ext;
    logic [core_pkg::xlen-1:0]       src_a;
    logic [core_pkg::xlen-1:0]       src_b;
    logic [core_pkg::xlen-1:0]       alu_res;
    logic [core_pkg::xlen-1:0]       pc_plus4;
    core_pkg::ls_req_t               ls_req_q;
    logic [core_pkg::xlen-1:0]       pend_pc_q;
    logic [core_pkg::reg_addr_w-1:0] pend_rt_q;
    core_pkg::commit_t               commit_d;
    core_pkg::commit_t               commit_q;

    assign op        = core_pkg::opcode_e'(head_i.instr[31:26]);
    assign rs_addr_o = head_i.instr[25:21];
    assign rt_addr_o = head_i.instr[20:16];
    assign rd        = head_i.instr[15:11];
    assign shamt     = head_i.instr[10:6];
    assign funct     = core_pkg::funct_e'(head_i.instr[5:0]);
    assign imm       = head_i.instr[15:0];
    assign jtarget   = head_i.instr[25:0];

    always_comb begin
        alu_op      = core_pkg::alu_add;
        sel_a_shamt = 1'b0;
        sel_b_imm   = 1'b1;
        zero_ext    = 1'b0;
        has_dest    = 1'b1;
        dest        = rt_addr_o;
        ls_op       = 1'b0;
        case (op)
            core_pkg::op_special: begin
                sel_b_imm = 1'b0;
                dest      = rd;
                case (funct)
                    core_pkg::fn_subu: alu_op = core_pkg::alu_sub;
                    core_pkg::fn_and:  alu_op = core_pkg::alu_and;
                    core_pkg::fn_or:   alu_op = core_pkg::alu_or;
                    core_pkg::fn_xor:  alu_op = core_pkg::alu_xor;
                    core_pkg::fn_slt:  alu_op = core_pkg::alu_slt;
                    core_pkg::fn_sll: begin
                        alu_op      = core_pkg::alu_sll;
                        sel_a_shamt = 1'b1;
                    end
                    default:           alu_op = core_pkg::alu_add;
                endcase
            end
            core_pkg::op_andi: begin
                alu_op   = core_pkg::alu_and;
                zero_ext = 1'b1;
            end
            core_pkg::op_ori: begin
                alu_op   = core_pkg::alu_or;
                zero_ext = 1'b1;
            end
            core_pkg::op_lui:   alu_op = core_pkg::alu_lui;
            core_pkg::op_addiu: alu_op = core_pkg::alu_add;
            core_pkg::op_lw:    ls_op = 1'b1;
            core_pkg::op_sw: begin
                ls_op    = 1'b1;
                has_dest = 1'b0;
            end
            // branches, jump and unknown opcodes write nothing
            default:            has_dest = 1'b0;
        endcase
    end

    assign imm_ext = zero_ext ? {16'b0, imm} : {{16{imm[15]}}, imm};
    assign src_a   = sel_a_shamt ? core_pkg::xlen'(shamt) : rs_data_i;
    assign src_b   = sel_b_imm ? imm_ext : rt_data_i;

    always_comb begin
        case (alu_op)
            core_pkg::alu_sub: alu_res = src_a - src_b;
            core_pkg::alu_and: alu_res = src_a & src_b;
            core_pkg::alu_or:  alu_res = src_a | src_b;
            core_pkg::alu_xor: alu_res = src_a ^ src_b;
            core_pkg::alu_slt: alu_res = core_pkg::xlen'($signed(src_a) < $signed(src_b));
            core_pkg::alu_sll: alu_res = src_b << src_a[4:0];
            core_pkg::alu_lui: alu_res = {src_b[15:0], 16'h0000};
            default:           alu_res = src_a + src_b;
        endcase
    end

    // branch resolution, no delay slot
    assign pc_plus4 = head_i.pc + 'd4;
    always_comb begin
        case (op)
            core_pkg::op_beq: taken = (rs_data_i == rt_data_i);
            core_pkg::op_bne: taken = (rs_data_i != rt_data_i);
            core_pkg::op_j:   taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    assign redirect_pc_o = (op == core_pkg::op_j) ? {pc_plus4[31:28], jtarget, 2'b00}
                                                  : pc_plus4 + {imm_ext[29:0], 2'b00};

    // a pending load or store blocks the next issue
    assign issue            = head_valid_i && !ls_req_q.valid;
    assign pop_o            = issue;
    assign redirect_valid_o = issue && taken;
    assign ls_finish        = ls_req_q.valid && ls_done_i;
    assign ls_req_o         = ls_req_q;
    assign commit_o         = commit_q;

    always_comb begin
        if (ls_finish) begin
            wr_dest = !ls_req_q.we;
            waddr_o = pend_rt_q;
            wdata_o = ls_rdata_i;
        end else begin
            wr_dest = has_dest && !ls_op;
            waddr_o = dest;
            wdata_o = alu_res;
        end
        wen_o             = (ls_finish || issue) && wr_dest && (waddr_o != '0);
        commit_d.valid    = ls_finish || (issue && !ls_op);
        commit_d.pc       = ls_finish ? pend_pc_q : head_i.pc;
        commit_d.rf_wen   = wen_o;
        commit_d.rf_wnum  = wr_dest ? waddr_o : '0;
        commit_d.rf_wdata = wr_dest ? wdata_o : '0;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ls_req_q <= '0;
            commit_q <= '0;
        end else begin
            commit_q <= commit_d;
            if (issue && ls_op) begin
                ls_req_q.valid <= 1'b1;
                ls_req_q.we    <= (op == core_pkg::op_sw);
                ls_req_q.addr  <= alu_res;
                ls_req_q.wdata <= rt_data_i;
            end else if (ls_finish) begin
                ls_req_q.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue && ls_op) begin
            pend_pc_q <= head_i.pc;
            pend_rt_q <= rt_addr_o;
        end
    end

endmodule

// File: hw/load_store_unit.sv
module load_store_unit (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  core_pkg::ls_req_t         ls_req_i,
    output logic                      ls_done_o,
    output logic [core_pkg::xlen-1:0] ls_rdata_o,
    output bus_pkg::wb_req_t          data_req_o,
    input  bus_pkg::wb_rsp_t          data_rsp_i
);

    typedef enum logic {
        ls_idle,
        ls_busy
    } ls_state_e;

    ls_state_e                    state_q;
    logic                         we_q;
    logic [bus_pkg::wb_adr_w-1:0] adr_q;
    logic [bus_pkg::wb_dat_w-1:0] dat_q;
    logic                         ack;

    assign ack        = (state_q == ls_busy) && data_rsp_i.ack;
    assign ls_done_o  = ack;
    // read data is valid in the ack cycle
    assign ls_rdata_o = data_rsp_i.dat;

    always_comb begin
        data_req_o     = '0;
        data_req_o.cyc = (state_q == ls_busy);
        data_req_o.stb = (state_q == ls_busy);
        data_req_o.we  = we_q;
        data_req_o.adr = adr_q;
        data_req_o.dat = dat_q;
        data_req_o.sel = '1;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ls_idle;
        end else if (state_q == ls_idle && ls_req_i.valid) begin
            state_q <= ls_busy;
        end else if (ack) begin
            state_q <= ls_idle;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ls_idle && ls_req_i.valid) begin
            we_q  <= ls_req_i.we;
            adr_q <= ls_req_i.addr;
            dat_q <= ls_req_i.wdata;
        end
    end

endmodule

// File: hw/bus_arbiter.sv
module bus_arbiter (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  bus_pkg::wb_req_t fetch_req_i,
    output bus_pkg::wb_rsp_t fetch_rsp_o,
    input  bus_pkg::wb_req_t data_req_i,
    output bus_pkg::wb_rsp_t data_rsp_o,
    output bus_pkg::wb_req_t mem_req_o,
    input  bus_pkg::wb_rsp_t mem_rsp_i
);

    typedef enum logic [1:0] {
        own_none,
        own_fetch,
        own_data
    } owner_e;

    owner_e owner_q;
    owner_e owner_d;

    // owner keeps the bus while its cyc is high, data wins when idle
    always_comb begin
        if (owner_q == own_fetch && fetch_req_i.cyc) begin
            owner_d = own_fetch;
        end else if (owner_q == own_data && data_req_i.cyc) begin
            owner_d = own_data;
        end else if (data_req_i.cyc) begin
            owner_d = own_data;
        end else if (fetch_req_i.cyc) begin
            owner_d = own_fetch;
        end else begin
            owner_d = own_none;
        end
    end

    always_comb begin
        case (owner_d)
            own_fetch: mem_req_o = fetch_req_i;
            own_data:  mem_req_o = data_req_i;
            default:   mem_req_o = '0;
        endcase
        fetch_rsp_o.ack = mem_rsp_i.ack && (owner_d == own_fetch);
        fetch_rsp_o.dat = mem_rsp_i.dat;
        data_rsp_o.ack  = mem_rsp_i.ack && (owner_d == own_data);
        data_rsp_o.dat  = mem_rsp_i.dat;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            owner_q <= own_none;
        end else begin
            owner_q <= owner_d;
        end
    end

endmodule

// File: hw/mips_lite_core.sv
module mips_lite_core (
    input  logic              clk_i,
    input  logic              arst_n_i,
    output bus_pkg::wb_req_t  mem_req_o,
    input  bus_pkg::wb_rsp_t  mem_rsp_i,
    output core_pkg::commit_t commit_o
);

    bus_pkg::wb_req_t                fetch_req;
    bus_pkg::wb_rsp_t                fetch_rsp;
    bus_pkg::wb_req_t                data_req;
    bus_pkg::wb_rsp_t                data_rsp;
    core_pkg::queue_entry_t          head;
    logic                            head_valid;
    logic                            pop;
    logic                            redirect_valid;
    logic [core_pkg::xlen-1:0]       redirect_pc;
    logic [core_pkg::reg_addr_w-1:0] rs_addr;
    logic [core_pkg::reg_addr_w-1:0] rt_addr;
    logic [core_pkg::xlen-1:0]       rs_data;
    logic [core_pkg::xlen-1:0]       rt_data;
    logic                            rf_wen;
    logic [core_pkg::reg_addr_w-1:0] rf_waddr;
    logic [core_pkg::xlen-1:0]       rf_wdata;
    core_pkg::ls_req_t               ls_req;
    logic                            ls_done;
    logic [core_pkg::xlen-1:0]       ls_rdata;

    fetch_queue u_fetch_queue (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .fetch_req_o      (fetch_req),
        .fetch_rsp_i      (fetch_rsp),
        .head_o           (head),
        .head_valid_o     (head_valid),
        .pop_i            (pop),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc)
    );

    decode_exec u_decode_exec (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .head_i           (head),
        .head_valid_i     (head_valid),
        .pop_o            (pop),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc),
        .rs_addr_o        (rs_addr),
        .rt_addr_o        (rt_addr),
        .rs_data_i        (rs_data),
        .rt_data_i        (rt_data),
        .wen_o            (rf_wen),
        .waddr_o          (rf_waddr),
        .wdata_o          (rf_wdata),
        .ls_req_o         (ls_req),
        .ls_done_i        (ls_done),
        .ls_rdata_i       (ls_rdata),
        .commit_o         (commit_o)
    );

    regfile u_regfile (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .ra_i     (rs_addr),
        .rb_i     (rt_addr),
        .rda_o    (rs_data),
        .rdb_o    (rt_data),
        .we_i     (rf_wen),
        .wa_i     (rf_waddr),
        .wd_i     (rf_wdata)
    );

    load_store_unit u_load_store_unit (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .ls_req_i   (ls_req),
        .ls_done_o  (ls_done),
        .ls_rdata_o (ls_rdata),
        .data_req_o (data_req),
        .data_rsp_i (data_rsp)
    );

    bus_arbiter u_bus_arbiter (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .fetch_req_i (fetch_req),
        .fetch_rsp_o (fetch_rsp),
        .data_req_i  (data_req),
        .data_rsp_o  (data_rsp),
        .mem_req_o   (mem_req_o),
        .mem_rsp_i   (mem_rsp_i)
    );

endmodule

// File: verif/trace_checker.sv
module trace_checker (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  bus_pkg::wb_req_t  mem_req_i,
    input  core_pkg::commit_t commit_i,
    output logic              done_o,
    output int                errors_o
);
    timeunit 1ns;
    timeprecision 1ps;

    core_pkg::commit_t exp_q[$];
    core_pkg::commit_t exp_rec;
    int                error_count = 0;
    logic              first_q = 1'b0;
    logic              done_q = 1'b0;

    assign done_o   = done_q;
    assign errors_o = error_count;

    // called by the testbench while loading the expected trace
    task automatic add_expected(input core_pkg::commit_t rec);
        exp_q.push_back(rec);
    endtask

    task automatic compare_field(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            error_count++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp_v, act_v);
        end
    endtask

    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            compare_field("mem_req.cyc", 32'd0, 32'(mem_req_i.cyc));
            compare_field("commit.valid", 32'd0, 32'(commit_i.valid));
            first_q <= 1'b1;
        end else begin
            // first edge out of reset still quiet
            if (first_q) begin
                compare_field("mem_req.cyc", 32'd0, 32'(mem_req_i.cyc));
                compare_field("commit.valid", 32'd0, 32'(commit_i.valid));
                first_q <= 1'b0;
            end
            if (commit_i.valid) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("commit at pc %h came after the end of the expected trace",
                             commit_i.pc);
                end else begin
                    exp_rec = exp_q.pop_front();
                    compare_field("commit.pc", exp_rec.pc, commit_i.pc);
                    compare_field("commit.rf_wen", 32'(exp_rec.rf_wen), 32'(commit_i.rf_wen));
                    // number and data only matter for a real write
                    if (exp_rec.rf_wen) begin
                        compare_field("commit.rf_wnum", 32'(exp_rec.rf_wnum),
                                      32'(commit_i.rf_wnum));
                        compare_field("commit.rf_wdata", exp_rec.rf_wdata, commit_i.rf_wdata);
                    end
                    if (exp_q.size() == 0) begin
                        done_q <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: verif/tb_top.sv
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int mem_words = 1024;
    localparam int timeout_cycles = 5000;

    logic              clk;
    logic              arst_n;
    bus_pkg::wb_req_t  mem_req;
    bus_pkg::wb_rsp_t  mem_rsp;
    core_pkg::commit_t commit;
    logic              trace_done;
    int                check_errors;
    int                tb_errors = 0;
    logic [31:0]       mem [mem_words];
    logic              busy;
    int                wait_cnt;
    int unsigned       delay;

    mips_lite_core mips_lite_core_i (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp),
        .commit_o  (commit)
    );

    trace_checker trace_checker_i (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .mem_req_i (mem_req),
        .commit_i  (commit),
        .done_o    (trace_done),
        .errors_o  (check_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // wishbone slave with 0 to 3 wait states per access
    always @(posedge clk) begin
        if (!arst_n) begin
            mem_rsp  <= '0;
            busy     <= 1'b0;
            wait_cnt <= 0;
        end else begin
            mem_rsp.ack <= 1'b0;
            if (!mem_rsp.ack && mem_req.cyc && mem_req.stb) begin
                if (!busy) begin
                    delay = $urandom % 4;
                end else begin
                    delay = 0;
                end
                if (busy && wait_cnt != 0) begin
                    wait_cnt <= wait_cnt - 1;
                end else if (!busy && delay != 0) begin
                    busy     <= 1'b1;
                    wait_cnt <= int'(delay) - 1;
                end else begin
                    busy        <= 1'b0;
                    mem_rsp.ack <= 1'b1;
                    if (mem_req.we) begin
                        mem[mem_req.adr[11:2]] = mem_req.dat;
                    end else begin
                        mem_rsp.dat <= mem[mem_req.adr[11:2]];
                    end
                end
            end
        end
    end

    task automatic load_image_and_trace();
        int                fd;
        int                n;
        string             line;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       c;
        logic [31:0]       d;
        core_pkg::commit_t rec;
        fd = $fopen("verif/core_testdata.txt", "r");
        if (fd == 0) begin
            tb_errors++;
            $display("could not open verif/core_testdata.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] == "M") begin
                n = $sscanf(line, "M %h %h", a, b);
                mem[a[11:2]] = b;
            end else if (n > 0 && line.len() > 0 && line[0] == "T") begin
                n = $sscanf(line, "T %h %h %h %h", a, b, c, d);
                rec          = '0;
                rec.valid    = 1'b1;
                rec.pc       = a;
                rec.rf_wen   = b[0];
                rec.rf_wnum  = c[4:0];
                rec.rf_wdata = d;
                trace_checker_i.add_expected(rec);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int cycles;
        void'($urandom(73125));
        arst_n  <= 1'b0;
        mem_rsp <= '0;
        // background pattern tied to the full word address
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = 32'hbad00000 | 32'(i);
        end
        load_image_and_trace();
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        cycles = 0;
        while (!trace_done && cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        @(negedge clk);
        if (!trace_done) begin
            tb_errors++;
            $display("timeout after %0d cycles before the expected trace was used up", cycles);
        end

        $display("errors: checker %0d, testbench %0d", check_errors, tb_errors);
        if (check_errors == 0 && tb_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: build.f
hw/core_pkg.sv
hw/bus_pkg.sv
hw/fetch_queue.sv
hw/regfile.sv
hw/decode_exec.sv
hw/load_store_unit.sv
hw/bus_arbiter.sv
hw/mips_lite_core.sv
verif/trace_checker.sv
verif/tb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, then decide from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_top -f build.f -o tb_top_sim \
    && ./obj_dir/tb_top_sim 2>&1 | tee sim.log \
    || echo "build or run error" >> sim.log

if grep -q "Simulation failed" sim.log || ! grep -q "Simulation passed" sim.log; then
    exit 1
fi
exit 0

// File: verif/core_testdata.txt
# M byte_address word : memory image
# T pc rf_wen rf_wnum rf_wdata : expected commit, all hex
M 00000000 24010005
M 00000004 2402fffd
M 00000008 00221821
M 0000000c 00412023
M 00000010 0041282a
M 00000014 0022302a
M 00000018 00223824
M 0000001c 00224025
M 00000020 00224826
M 00000024 00015100
M 00000028 304b00f0
M 0000002c 342c1200
M 00000030 3c0dabcd
M 00000034 ac0d0100
M 00000038 8c0e0100
M 0000003c 8c0f0200
M 00000040 24000007
M 00000044 00018021
M 00000048 10210002
M 0000004c 24140001
M 00000050 24140002
M 00000054 14220001
M 00000058 24140003
M 0000005c 10220005
M 00000060 24110011
M 00000064 0800001c
M 00000068 24140004
M 0000006c 24140005
M 00000070 01cf9021
M 00000074 0800001d
M 00000100 deadbeef
M 00000200 13572468
T 00000000 1 01 00000005
T 00000004 1 02 fffffffd
T 00000008 1 03 00000002
T 0000000c 1 04 fffffff8
T 00000010 1 05 00000001
T 00000014 1 06 00000000
T 00000018 1 07 00000005
T 0000001c 1 08 fffffffd
T 00000020 1 09 fffffff8
T 00000024 1 0a 00000050
T 00000028 1 0b 000000f0
T 0000002c 1 0c 00001205
T 00000030 1 0d abcd0000
T 00000034 0 00 00000000
T 00000038 1 0e abcd0000
T 0000003c 1 0f 13572468
T 00000040 0 00 00000000
T 00000044 1 10 00000005
T 00000048 0 00 00000000
T 00000054 0 00 00000000
T 0000005c 0 00 00000000
T 00000060 1 11 00000011
T 00000064 0 00 00000000
T 00000070 1 12 bf242468
T 00000074 0 00 00000000
